// ==== include/bridge_consts.svh ====
// bridge register map and field positions, included by the bridge RTL and its testbench
`ifndef BRIDGE_CONSTS_SVH
`define BRIDGE_CONSTS_SVH

// --------------------------------------------------
// host register addressing
// --------------------------------------------------
// register index width
`define REG_ADDR_W 3
// byte select inside one 32-bit register
`define BYTECNT_W 2

// register indexes
`define REG_INSTR  3'd0
`define REG_ADDR   3'd1
`define REG_WDATA  3'd2
`define REG_RDATA  3'd3
`define REG_STATUS 3'd4
`define REG_COUNT  3'd5

// instruction byte fields, op in the low bits, byte enables on top
`define INSTR_OP_LSB 0
`define INSTR_BE_LSB 4

// status byte bit positions
`define ST_BUSY        0
`define ST_INSTR_VALID 1
`define ST_ADDR_VALID  2
`define ST_ERR         3

// completion counter width
`define COUNT_W 16

`endif

// ==== logic/bridge_pkg.sv ====
// common word, byte, byte-enable and bus operation types, imported by every bridge module
package bridge_pkg;

  // --------------------------------------------------
  // data types
  // --------------------------------------------------
  // one host register byte
  typedef logic [7:0] byte_t;

  // bus address and data word
  typedef logic [31:0] word_t;

  // OBI byte enables, one per byte lane
  typedef logic [3:0] be_t;

  // --------------------------------------------------
  // bus operation
  // --------------------------------------------------
  // encoding 3 is reserved and rejected by the decoder
  typedef enum logic [1:0] {
    OP_NONE  = 2'd0,
    OP_WRITE = 2'd1,
    OP_READ  = 2'd2
  } obi_op_e;

endpackage

// ==== logic/bridge_top.sv ====
// top of the host to OBI command bridge, host register port in, OBI master port out
`timescale 1ns/1ps
`include "bridge_consts.svh"

module bridge_top
  import bridge_pkg::*;
(
  input  logic                   heep_clk,
  input  logic                   rst_n_i,
  // host register port
  input  logic [`REG_ADDR_W-1:0] reg_address_i,
  input  logic [`BYTECNT_W-1:0]  reg_bytecnt_i,
  input  byte_t                  reg_wdata_i,
  input  logic                   reg_write_i,
  output byte_t                  reg_rdata_o,
  // OBI master port
  output logic                   obi_req_o,
  output logic                   obi_we_o,
  output be_t                    obi_be_o,
  output word_t                  obi_addr_o,
  output word_t                  obi_wdata_o,
  input  logic                   obi_gnt_i,
  input  logic                   obi_rvalid_i,
  input  word_t                  obi_rdata_i,
  // transaction finished
  output logic                   done_o
);

  // --------------------------------------------------
  // decode to execute
  // --------------------------------------------------
  logic    cmd_valid;
  obi_op_e cmd_op;
  be_t     cmd_be;
  word_t   cmd_addr;
  word_t   cmd_wdata;
  logic    cmd_accept;
  logic    busy;

  // execute to result, result to decode
  logic                cpl_valid;
  logic                cpl_read;
  word_t               last_rdata;
  logic [`COUNT_W-1:0] cpl_count;

  cmd_decode u_cmd_decode (
    .heep_clk      (heep_clk),
    .rst_n_i       (rst_n_i),
    .reg_address_i (reg_address_i),
    .reg_bytecnt_i (reg_bytecnt_i),
    .reg_wdata_i   (reg_wdata_i),
    .reg_write_i   (reg_write_i),
    .reg_rdata_o   (reg_rdata_o),
    .busy_i        (busy),
    .cmd_accept_i  (cmd_accept),
    .last_rdata_i  (last_rdata),
    .cpl_count_i   (cpl_count),
    .cmd_valid_o   (cmd_valid),
    .cmd_op_o      (cmd_op),
    .cmd_be_o      (cmd_be),
    .cmd_addr_o    (cmd_addr),
    .cmd_wdata_o   (cmd_wdata)
  );

  obi_execute u_obi_execute (
    .heep_clk     (heep_clk),
    .rst_n_i      (rst_n_i),
    .cmd_valid_i  (cmd_valid),
    .cmd_op_i     (cmd_op),
    .cmd_be_i     (cmd_be),
    .cmd_addr_i   (cmd_addr),
    .cmd_wdata_i  (cmd_wdata),
    .cmd_accept_o (cmd_accept),
    .busy_o       (busy),
    .obi_req_o    (obi_req_o),
    .obi_we_o     (obi_we_o),
    .obi_be_o     (obi_be_o),
    .obi_addr_o   (obi_addr_o),
    .obi_wdata_o  (obi_wdata_o),
    .obi_gnt_i    (obi_gnt_i),
    .obi_rvalid_i (obi_rvalid_i),
    .cpl_valid_o  (cpl_valid),
    .cpl_read_o   (cpl_read)
  );

  // rdata goes straight from the bus to capture
  result_capture u_result_capture (
    .heep_clk     (heep_clk),
    .rst_n_i      (rst_n_i),
    .cpl_valid_i  (cpl_valid),
    .cpl_read_i   (cpl_read),
    .obi_rdata_i  (obi_rdata_i),
    .last_rdata_o (last_rdata),
    .cpl_count_o  (cpl_count),
    .done_o       (done_o)
  );

endmodule

// ==== logic/cmd_decode.sv ====
// host side register file: byte writes, command arming, status and byte-wide read-back
`timescale 1ns/1ps
`include "bridge_consts.svh"

module cmd_decode
  import bridge_pkg::*;
(
  input  logic                   heep_clk,
  input  logic                   rst_n_i,
  // host register port
  input  logic [`REG_ADDR_W-1:0] reg_address_i,
  input  logic [`BYTECNT_W-1:0]  reg_bytecnt_i,
  input  byte_t                  reg_wdata_i,
  input  logic                   reg_write_i,
  output byte_t                  reg_rdata_o,
  // execute handshake
  input  logic                   busy_i,
  input  logic                   cmd_accept_i,
  // results for read-back
  input  word_t                  last_rdata_i,
  input  logic [`COUNT_W-1:0]    cpl_count_i,
  // armed command
  output logic                   cmd_valid_o,
  output obi_op_e                cmd_op_o,
  output be_t                    cmd_be_o,
  output word_t                  cmd_addr_o,
  output word_t                  cmd_wdata_o
);

  // host visible registers
  obi_op_e instr_op_q;
  be_t     instr_be_q;
  word_t   addr_q;
  word_t   wdata_q;
  logic    instr_valid_q;
  logic    addr_valid_q;
  logic    err_q;

  // decode helpers
  logic                        wr_instr;
  logic                        wr_addr;
  logic                        wr_wdata;
  logic                        wr_status;
  logic [$bits(obi_op_e)-1:0]  op_field;
  be_t                         be_field;
  logic                        op_legal;
  logic                        instr_ok;
  byte_t                       instr_byte;
  byte_t                       status_byte;
  word_t                       count_word;

  // --------------------------------------------------
  // write decode
  // --------------------------------------------------
  // only byte 0 of the instruction register exists
  assign wr_instr  = reg_write_i && (reg_address_i == `REG_INSTR) && (reg_bytecnt_i == '0);
  assign wr_addr   = reg_write_i && (reg_address_i == `REG_ADDR);
  assign wr_wdata  = reg_write_i && (reg_address_i == `REG_WDATA);
  // any status byte clears err
  assign wr_status = reg_write_i && (reg_address_i == `REG_STATUS);

  assign op_field = reg_wdata_i[`INSTR_OP_LSB +: $bits(obi_op_e)];
  assign be_field = reg_wdata_i[`INSTR_BE_LSB +: $bits(be_t)];
  assign op_legal = (op_field == OP_WRITE) || (op_field == OP_READ);
  // armed or running command blocks a new instruction
  assign instr_ok = op_legal && !busy_i && !cmd_valid_o;

  // instruction, valid flag and sticky err
  always_ff @(posedge heep_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      instr_op_q    <= OP_NONE;
      instr_be_q    <= '0;
      instr_valid_q <= 1'b0;
      err_q         <= 1'b0;
    end else begin
      if (wr_instr && instr_ok) begin
        instr_op_q    <= obi_op_e'(op_field);
        instr_be_q    <= be_field;
        instr_valid_q <= 1'b1;
      end else if (cmd_accept_i) begin
        instr_valid_q <= 1'b0;
      end
      // rejected instruction leaves the pending one alone
      if (wr_instr && !instr_ok) begin
        err_q <= 1'b1;
      end else if (wr_status) begin
        err_q <= 1'b0;
      end
    end
  end

  // address and write data, little-endian byte lanes
  always_ff @(posedge heep_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      addr_q       <= '0;
      wdata_q      <= '0;
      addr_valid_q <= 1'b0;
    end else begin
      if (wr_addr) begin
        addr_q[{reg_bytecnt_i, 3'b000} +: 8] <= reg_wdata_i;
        // top byte completes the address, stays valid afterwards
        if (reg_bytecnt_i == '1) begin
          addr_valid_q <= 1'b1;
        end
      end
      if (wr_wdata) begin
        wdata_q[{reg_bytecnt_i, 3'b000} +: 8] <= reg_wdata_i;
      end
    end
  end

  // --------------------------------------------------
  // command to execute
  // --------------------------------------------------
  assign cmd_valid_o = instr_valid_q && addr_valid_q;
  assign cmd_op_o    = instr_op_q;
  assign cmd_be_o    = instr_be_q;
  assign cmd_addr_o  = addr_q;
  assign cmd_wdata_o = wdata_q;

  // --------------------------------------------------
  // read-back
  // --------------------------------------------------
  always_comb begin
    instr_byte = '0;
    instr_byte[`INSTR_OP_LSB +: $bits(obi_op_e)] = instr_op_q;
    instr_byte[`INSTR_BE_LSB +: $bits(be_t)]     = instr_be_q;
    status_byte = '0;
    status_byte[`ST_BUSY]        = busy_i;
    status_byte[`ST_INSTR_VALID] = instr_valid_q;
    status_byte[`ST_ADDR_VALID]  = addr_valid_q;
    status_byte[`ST_ERR]         = err_q;
  end

  // counter zero extended to a full word
  assign count_word = word_t'(cpl_count_i);

  always_comb begin
    reg_rdata_o = '0;
    case (reg_address_i)
      `REG_INSTR: begin
        if (reg_bytecnt_i == '0) begin
          reg_rdata_o = instr_byte;
        end
      end
      `REG_ADDR:   reg_rdata_o = addr_q[{reg_bytecnt_i, 3'b000} +: 8];
      `REG_WDATA:  reg_rdata_o = wdata_q[{reg_bytecnt_i, 3'b000} +: 8];
      `REG_RDATA:  reg_rdata_o = last_rdata_i[{reg_bytecnt_i, 3'b000} +: 8];
      `REG_STATUS: begin
        if (reg_bytecnt_i == '0) begin
          reg_rdata_o = status_byte;
        end
      end
      `REG_COUNT:  reg_rdata_o = count_word[{reg_bytecnt_i, 3'b000} +: 8];
      default:     reg_rdata_o = '0;
    endcase
  end

  // a running transaction never lets a new instruction arm
  a_no_arm_while_busy: assert property (
    @(posedge heep_clk) disable iff (!rst_n_i)
    busy_i |=> !$rose(instr_valid_q)
  ) else $error("instruction armed while bridge busy");

  // execute only takes what decode offers
  a_accept_needs_cmd: assert property (
    @(posedge heep_clk) disable iff (!rst_n_i)
    cmd_accept_i |-> cmd_valid_o
  ) else $error("command accepted without a valid command");

endmodule

// ==== logic/obi_execute.sv ====
// OBI bus master of the bridge: takes one armed command and runs a single bus transaction
`timescale 1ns/1ps

module obi_execute
  import bridge_pkg::*;
(
  input  logic    heep_clk,
  input  logic    rst_n_i,
  // command from decode
  input  logic    cmd_valid_i,
  input  obi_op_e cmd_op_i,
  input  be_t     cmd_be_i,
  input  word_t   cmd_addr_i,
  input  word_t   cmd_wdata_i,
  output logic    cmd_accept_o,
  output logic    busy_o,
  // OBI master port
  output logic    obi_req_o,
  output logic    obi_we_o,
  output be_t     obi_be_o,
  output word_t   obi_addr_o,
  output word_t   obi_wdata_o,
  input  logic    obi_gnt_i,
  input  logic    obi_rvalid_i,
  // completion to result capture
  output logic    cpl_valid_o,
  output logic    cpl_read_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_WAIT
  } exec_state_e;

  exec_state_e state_q;
  exec_state_e state_d;

  // latched command copy, drives the bus
  logic  we_q;
  be_t   be_q;
  word_t addr_q;
  word_t wdata_q;

  // --------------------------------------------------
  // FSM
  // --------------------------------------------------
  // take the command only from idle
  assign cmd_accept_o = (state_q == ST_IDLE) && cmd_valid_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (cmd_valid_i) begin
          state_d = ST_REQ;
        end
      end
      // hold req until granted
      ST_REQ: begin
        if (obi_gnt_i) begin
          state_d = ST_WAIT;
        end
      end
      // response phase
      ST_WAIT: begin
        if (obi_rvalid_i) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge heep_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // snapshot at accept, later host writes stay out of the transaction
  always_ff @(posedge heep_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      we_q    <= 1'b0;
      be_q    <= '0;
      addr_q  <= '0;
      wdata_q <= '0;
    end else if (cmd_accept_o) begin
      we_q    <= (cmd_op_i == OP_WRITE);
      // reads fetch the whole word
      be_q    <= (cmd_op_i == OP_READ) ? '1 : cmd_be_i;
      addr_q  <= cmd_addr_i;
      wdata_q <= cmd_wdata_i;
    end
  end

  // --------------------------------------------------
  // outputs
  // --------------------------------------------------
  assign busy_o      = (state_q != ST_IDLE);
  assign obi_req_o   = (state_q == ST_REQ);
  assign obi_we_o    = we_q;
  assign obi_be_o    = be_q;
  assign obi_addr_o  = addr_q;
  assign obi_wdata_o = wdata_q;

  // completion in the rvalid cycle, rdata still on the bus
  assign cpl_valid_o = (state_q == ST_WAIT) && obi_rvalid_i;
  assign cpl_read_o  = cpl_valid_o && !we_q;

  // OBI rule, request fields frozen until grant
  a_req_stable: assert property (
    @(posedge heep_clk) disable iff (!rst_n_i)
    obi_req_o && !obi_gnt_i |=> obi_req_o && $stable(obi_we_o) && $stable(obi_be_o)
                               && $stable(obi_addr_o) && $stable(obi_wdata_o)
  ) else $error("OBI request changed before grant");

  // slave answers only an outstanding grant
  a_no_rvalid_idle: assert property (
    @(posedge heep_clk) disable iff (!rst_n_i)
    (state_q == ST_IDLE) |-> !obi_rvalid_i
  ) else $error("rvalid with no transaction outstanding");

endmodule

// ==== logic/result_capture.sv ====
// completion side of the bridge: holds last read data, counts transactions, pulses done
`timescale 1ns/1ps
`include "bridge_consts.svh"

module result_capture
  import bridge_pkg::*;
(
  input  logic                heep_clk,
  input  logic                rst_n_i,
  // completion from execute
  input  logic                cpl_valid_i,
  input  logic                cpl_read_i,
  input  word_t               obi_rdata_i,
  // read-back values
  output word_t               last_rdata_o,
  output logic [`COUNT_W-1:0] cpl_count_o,
  // end of transaction
  output logic                done_o
);

  word_t               last_rdata_q;
  logic [`COUNT_W-1:0] count_q;
  logic                done_q;

  // --------------------------------------------------
  // capture
  // --------------------------------------------------
  always_ff @(posedge heep_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      last_rdata_q <= '0;
      count_q      <= '0;
      done_q       <= 1'b0;
    end else begin
      // writes keep the previous read data
      if (cpl_read_i) begin
        last_rdata_q <= obi_rdata_i;
      end
      // wraps at 16 bits
      if (cpl_valid_i) begin
        count_q <= count_q + 1'b1;
      end
      // single cycle, one per completion
      done_q <= cpl_valid_i;
    end
  end

  assign last_rdata_o = last_rdata_q;
  assign cpl_count_o  = count_q;
  assign done_o       = done_q;

  // read flag is qualified by the completion
  a_read_with_valid: assert property (
    @(posedge heep_clk) disable iff (!rst_n_i)
    cpl_read_i |-> cpl_valid_i
  ) else $error("read completion flagged without completion");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f --top-module tb_bridge_top -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
  exit 1
fi
exit 0

// ==== sim/obi_mem_model.sv ====
// OBI slave memory for the bridge testbench, random grant and response delays
`timescale 1ns/1ps

module obi_mem_model (
  input  logic        heep_clk,
  input  logic        rst_n_i,
  input  logic        req_i,
  input  logic        we_i,
  input  logic [3:0]  be_i,
  input  logic [31:0] addr_i,
  input  logic [31:0] wdata_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o
);

  logic [31:0] mem [16];
  logic [31:0] rng_q;
  logic [1:0]  gnt_wait_q;
  logic        resp_pend_q;
  logic [1:0]  resp_wait_q;

  // xorshift step for the delay generator
  function automatic logic [31:0] next_rand(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // --------------------------------------------------
  // handshake
  // --------------------------------------------------
  // one outstanding transaction at a time
  assign gnt_o    = req_i && !resp_pend_q && (gnt_wait_q == 2'd0);
  assign rvalid_o = resp_pend_q && (resp_wait_q == 2'd0);

  always_ff @(posedge heep_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rng_q       <= 32'he24c;
      gnt_wait_q  <= 2'd0;
      resp_pend_q <= 1'b0;
      resp_wait_q <= 2'd0;
      rdata_o     <= '0;
      for (int i = 0; i < 16; i++) begin
        mem[i] <= '0;
      end
    end else begin
      rng_q <= next_rand(rng_q);
      if (gnt_o) begin
        // word index from address bits 5:2
        if (we_i) begin
          for (int b = 0; b < 4; b++) begin
            if (be_i[b]) begin
              mem[addr_i[5:2]][8*b +: 8] <= wdata_i[8*b +: 8];
            end
          end
        end else begin
          rdata_o <= mem[addr_i[5:2]];
        end
        resp_pend_q <= 1'b1;
        // response 1 to 3 cycles after grant
        resp_wait_q <= 2'(rng_q[7:0] % 3);
        // grant delay 0 to 3 for the next request
        gnt_wait_q  <= rng_q[9:8];
      end else if (req_i && !resp_pend_q && gnt_wait_q != 2'd0) begin
        gnt_wait_q <= gnt_wait_q - 2'd1;
      end
      if (rvalid_o) begin
        resp_pend_q <= 1'b0;
      end else if (resp_pend_q && resp_wait_q != 2'd0) begin
        resp_wait_q <= resp_wait_q - 2'd1;
      end
    end
  end

endmodule

// ==== sim/tb_bridge_top.sv ====
// testbench for the host to OBI bridge, drives host registers against a memory model
`timescale 1ns/1ps
`include "bridge_consts.svh"

module tb_bridge_top;

  logic                   heep_clk;
  logic                   rst_n_i;
  logic [`REG_ADDR_W-1:0] reg_address_i;
  logic [`BYTECNT_W-1:0]  reg_bytecnt_i;
  logic [7:0]             reg_wdata_i;
  logic                   reg_write_i;
  logic [7:0]             reg_rdata_o;
  logic                   obi_req_o;
  logic                   obi_we_o;
  logic [3:0]             obi_be_o;
  logic [31:0]            obi_addr_o;
  logic [31:0]            obi_wdata_o;
  logic                   obi_gnt_i;
  logic                   obi_rvalid_i;
  logic [31:0]            obi_rdata_i;
  logic                   done_o;

  // checker controls, driven with the stimulus
  logic        arm_flag;
  logic        idle_chk;
  logic        rd_chk;
  logic [7:0]  rd_exp;
  logic        cnt_chk;
  int          cnt_exp;
  int          done_cnt;
  int          errors;
  int          cycles;
  int          tests_passed;
  int          tests_failed;
  int          txn_cnt;
  logic [31:0] rng;
  logic [31:0] mirror [16];

  bridge_top u_bridge_top (.*);

  obi_mem_model u_mem (
    .heep_clk (heep_clk),
    .rst_n_i  (rst_n_i),
    .req_i    (obi_req_o),
    .we_i     (obi_we_o),
    .be_i     (obi_be_o),
    .addr_i   (obi_addr_o),
    .wdata_i  (obi_wdata_o),
    .gnt_o    (obi_gnt_i),
    .rvalid_o (obi_rvalid_i),
    .rdata_o  (obi_rdata_i)
  );

  // 100 ns period
  always #50 heep_clk = ~heep_clk;

  // --------------------------------------------------
  // checking assertions
  // --------------------------------------------------
  a_readback: assert property (@(posedge heep_clk) rd_chk |-> reg_rdata_o == rd_exp)
    else begin
      errors++;
      $display("CHECK FAILED at %0t: read-back 0x%02h, expected 0x%02h",
               $time, $sampled(reg_rdata_o), $sampled(rd_exp));
    end

  // arming edge, accept edge, then req
  a_req_timing: assert property (@(posedge heep_clk) disable iff (!rst_n_i)
    reg_write_i && arm_flag |=> !obi_req_o ##1 obi_req_o)
    else begin
      errors++;
      $display("CHECK FAILED at %0t: request not raised 2 cycles after arming write", $time);
    end

  a_bus_idle: assert property (@(posedge heep_clk) idle_chk |-> !obi_req_o && !done_o)
    else begin
      errors++;
      $display("CHECK FAILED at %0t: bus request or done while bridge should be idle", $time);
    end

  a_done_single: assert property (@(posedge heep_clk) disable iff (!rst_n_i)
    done_o |=> !done_o)
    else begin
      errors++;
      $display("CHECK FAILED at %0t: done pulse longer than one cycle", $time);
    end

  a_hold_fields: assert property (@(posedge heep_clk) disable iff (!rst_n_i)
    obi_req_o && !obi_gnt_i |=> $stable(obi_addr_o) && $stable(obi_wdata_o)
                               && $stable(obi_be_o))
    else begin
      errors++;
      $display("CHECK FAILED at %0t: request fields changed before grant", $time);
    end

  // reads fetch the whole word whatever the instruction enables
  a_read_be: assert property (@(posedge heep_clk) disable iff (!rst_n_i)
    obi_req_o && !obi_we_o |-> obi_be_o == 4'hf)
    else begin
      errors++;
      $display("CHECK FAILED at %0t: read request with byte enables 0x%01h, expected 0xf",
               $time, $sampled(obi_be_o));
    end

  a_done_count: assert property (@(posedge heep_clk) cnt_chk |-> done_cnt == cnt_exp)
    else begin
      errors++;
      $display("CHECK FAILED at %0t: %0d done pulses, expected %0d",
               $time, $sampled(done_cnt), $sampled(cnt_exp));
    end

  always @(posedge heep_clk) begin
    if (done_o) begin
      done_cnt++;
    end
    cycles++;
    // longest run is about six tests of 40 transactions at 12 cycles
    if (cycles >= 3000) begin
      $display("timeout: run did not finish within 3000 cycles");
      $display("Simulation failed");
      $finish;
    end
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // one strobe, entered and left 10 ns after a rising edge
  task automatic write_reg(input logic [2:0] idx, input logic [1:0] bsel,
                           input logic [7:0] data, input logic arm);
    reg_address_i = idx;
    reg_bytecnt_i = bsel;
    reg_wdata_i   = data;
    reg_write_i   = 1'b1;
    arm_flag      = arm;
    @(posedge heep_clk);
    #10;
    reg_write_i = 1'b0;
    arm_flag    = 1'b0;
  endtask

  task automatic write_word(input logic [2:0] idx, input logic [31:0] data);
    for (int b = 0; b < 4; b++) begin
      write_reg(idx, 2'(b), data[8*b +: 8], 1'b0);
    end
  endtask

  task automatic check_byte(input logic [2:0] idx, input logic [1:0] bsel,
                            input logic [7:0] exp);
    reg_address_i = idx;
    reg_bytecnt_i = bsel;
    rd_exp        = exp;
    rd_chk        = 1'b1;
    @(posedge heep_clk);
    #10;
    rd_chk = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    idle_chk = 1'b1;
    repeat (n) begin
      @(posedge heep_clk);
      #10;
    end
    idle_chk = 1'b0;
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    do begin
      @(posedge heep_clk);
      #10;
      n++;
    end while (!done_o && n < 40);
    if (!done_o) begin
      errors++;
      $display("no done pulse within 40 cycles of the command at %0t", $time);
    end
    txn_cnt++;
  endtask

  task automatic mirror_write(input logic [3:0] be, input logic [31:0] addr,
                              input logic [31:0] data);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        mirror[addr[5:2]][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  task automatic run_txn(input logic [1:0] op, input logic [3:0] be,
                         input logic [31:0] addr, input logic [31:0] data);
    write_word(`REG_ADDR, addr);
    write_word(`REG_WDATA, data);
    write_reg(`REG_INSTR, 2'd0, {be, 2'b00, op}, 1'b1);
    wait_done();
    if (op == 2'd1) begin
      mirror_write(be, addr, data);
    end
  endtask

  task automatic read_compare(input logic [31:0] addr);
    run_txn(2'd2, 4'hf, addr, 32'h0);
    for (int b = 0; b < 4; b++) begin
      check_byte(`REG_RDATA, 2'(b), mirror[addr[5:2]][8*b +: 8]);
    end
  endtask

  task automatic check_count();
    check_byte(`REG_COUNT, 2'd0, txn_cnt[7:0]);
    check_byte(`REG_COUNT, 2'd1, txn_cnt[15:8]);
    cnt_exp = txn_cnt;
    cnt_chk = 1'b1;
    @(posedge heep_clk);
    #10;
    cnt_chk = 1'b0;
  endtask

  task automatic end_test(input string name, input int err_before);
    if (errors == err_before) begin
      tests_passed++;
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: FAIL (%0d errors)", name, errors - err_before);
    end
  endtask

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial begin
    int          e;
    logic [31:0] a;
    logic [31:0] d;
    heep_clk = 1'b0;
    rst_n_i = 1'b0;
    reg_address_i = '0;
    reg_bytecnt_i = '0;
    reg_wdata_i = '0;
    reg_write_i = 1'b0;
    arm_flag = 1'b0;
    idle_chk = 1'b0;
    rd_chk = 1'b0;
    rd_exp = '0;
    cnt_chk = 1'b0;
    cnt_exp = 0;
    done_cnt = 0;
    errors = 0;
    cycles = 0;
    tests_passed = 0;
    tests_failed = 0;
    txn_cnt = 0;
    rng = 32'he24c;
    for (int i = 0; i < 16; i++) begin
      mirror[i] = '0;
    end
    repeat (8) @(posedge heep_clk);
    #10;
    rst_n_i = 1'b1;

    e = errors;
    idle_cycles(2);
    check_byte(`REG_STATUS, 2'd0, 8'h00);
    check_count();
    end_test("reset state", e);

    // instruction first, address arms it
    e = errors;
    idle_chk = 1'b1;
    write_reg(`REG_INSTR, 2'd0, 8'hf1, 1'b0);
    write_word(`REG_WDATA, 32'hcafe_f00d);
    for (int b = 0; b < 3; b++) begin
      write_reg(`REG_ADDR, 2'(b), 8'h10 + 8'(b), 1'b0);
    end
    idle_chk = 1'b0;
    write_reg(`REG_ADDR, 2'd3, 8'h00, 1'b1);
    wait_done();
    mirror_write(4'hf, 32'h0012_1110, 32'hcafe_f00d);
    read_compare(32'h0012_1110);
    end_test("pending address", e);

    e = errors;
    for (int i = 0; i < 20; i++) begin
      rng = xorshift(rng);
      a = {rng[31:2], 2'b00};
      rng = xorshift(rng);
      d = rng;
      run_txn(2'd1, 4'hf, a, d);
      read_compare(a);
    end
    check_count();
    end_test("write then read", e);

    e = errors;
    for (int i = 0; i < 10; i++) begin
      rng = xorshift(rng);
      a = {rng[31:2], 2'b00};
      rng = xorshift(rng);
      run_txn(2'd1, rng[3:0], a, xorshift(rng));
      read_compare(a);
    end
    end_test("byte enables", e);

    // host rewrites address and data while the request waits
    e = errors;
    for (int i = 0; i < 5; i++) begin
      rng = xorshift(rng);
      a = {rng[31:2], 2'b00};
      d = xorshift(rng);
      write_word(`REG_ADDR, a);
      write_word(`REG_WDATA, d);
      write_reg(`REG_INSTR, 2'd0, 8'hf1, 1'b1);
      write_reg(`REG_ADDR, 2'd0, ~a[7:0], 1'b0);
      write_reg(`REG_WDATA, 2'd0, ~d[7:0], 1'b0);
      wait_done();
      mirror_write(4'hf, a, d);
      read_compare(a);
    end
    end_test("back-pressure", e);

    e = errors;
    write_reg(`REG_INSTR, 2'd0, 8'hf3, 1'b0);
    idle_cycles(4);
    check_byte(`REG_STATUS, 2'd0, 8'h0c);
    write_reg(`REG_STATUS, 2'd0, 8'h00, 1'b0);
    check_byte(`REG_STATUS, 2'd0, 8'h04);
    write_reg(`REG_INSTR, 2'd0, 8'hf0, 1'b0);
    idle_cycles(4);
    check_byte(`REG_STATUS, 2'd0, 8'h0c);
    write_reg(`REG_STATUS, 2'd1, 8'h00, 1'b0);
    write_word(`REG_ADDR, 32'h0000_0020);
    write_reg(`REG_INSTR, 2'd0, 8'h12, 1'b1);
    // accept edge, the request is up from here
    check_byte(`REG_STATUS, 2'd0, 8'h06);
    // bridge busy with the read, this one is rejected
    write_reg(`REG_INSTR, 2'd0, 8'hf1, 1'b0);
    wait_done();
    check_byte(`REG_STATUS, 2'd0, 8'h0c);
    check_count();
    write_reg(`REG_STATUS, 2'd0, 8'h00, 1'b0);
    check_byte(`REG_STATUS, 2'd0, 8'h04);
    end_test("errors", e);

    $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+include
logic/bridge_pkg.sv
logic/cmd_decode.sv
logic/obi_execute.sv
logic/result_capture.sv
logic/bridge_top.sv
sim/obi_mem_model.sv
sim/tb_bridge_top.sv
